// File: design/la_macros.svh
`ifndef LA_MACROS_SVH
`define LA_MACROS_SVH

// serial link, clock cycles per bit
`define CLKS_PER_BAUD 66

// bus address and data width
`define BUS_WIDTH 16

// sample memory
`define SAMPLE_DEPTH 64
`define SAMPLE_ADDR_WIDTH 6

`define NUM_PROBES 7

// bus regions, upper nibble of the address
`define REGION_CTRL 4'd0
`define REGION_TRIG 4'd1
`define REGION_MEM 4'd2

`endif

// File: design/la_pkg.sv
`include "la_macros.svh"

package la_pkg;

    // region/offset view of a bus address
    typedef struct packed {
        logic [3:0] region;
        logic [`BUS_WIDTH-5:0] offset;
    } bus_addr_split_t;

    // the bridge fills raw, the bus stages decode split
    typedef union packed {
        logic [`BUS_WIDTH-1:0] raw;
        bus_addr_split_t split;
    } bus_addr_u;

    typedef struct packed {
        bus_addr_u addr;
        logic [`BUS_WIDTH-1:0] data;
        logic rw;
        logic valid;
    } bus_req_t;

    typedef struct packed {
        logic [`BUS_WIDTH-1:0] data;
        logic valid;
    } bus_rsp_t;

    // valid_in sits in bit 0
    typedef struct packed {
        logic pclk_cam;
        logic tuser_out;
        logic ready_out;
        logic valid_out;
        logic newframe_in;
        logic ready_in;
        logic valid_in;
    } probe_t;

    typedef enum logic [3:0] {
        DISABLE = 4'd0,
        RISING = 4'd1,
        FALLING = 4'd2,
        CHANGING = 4'd3,
        EQ = 4'd8,
        NEQ = 4'd9
    } trig_op_e;

    typedef enum logic [1:0] {
        IDLE = 2'd0,
        ARMED = 2'd1,
        CAPTURING = 2'd2,
        CAPTURED = 2'd3
    } la_state_e;

endpackage

// File: design/uart_rx.sv
`timescale 1ns/1ps
`include "la_macros.svh"

module uart_rx (
    input logic clk,
    input logic reset_i,
    input logic rx_i,
    output logic [7:0] data_o,
    output logic valid_o
);

    localparam int CW = $clog2(`CLKS_PER_BAUD * 2);
    localparam logic [3:0] ST_IDLE = 4'd0;
    localparam logic [3:0] ST_STOP = 4'd9;

    logic rx_meta;
    logic rx_sync;
    logic [3:0] state;
    logic [CW-1:0] baud_cnt;
    logic baud_zero;

    assign baud_zero = (baud_cnt == '0);

    // two-flop synchronizer, line idles high
    always_ff @(posedge clk) begin
        if (reset_i) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
        end else begin
            rx_meta <= rx_i;
            rx_sync <= rx_meta;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state <= ST_IDLE;
            baud_cnt <= '0;
            valid_o <= 1'b0;
        end else begin
            valid_o <= 1'b0;
            if (state == ST_IDLE) begin
                // wait out the start bit plus half a bit to land mid-bit
                if (!rx_sync) begin
                    state <= 4'd1;
                    baud_cnt <= CW'(`CLKS_PER_BAUD + `CLKS_PER_BAUD / 2 - 1);
                end
            end else if (baud_zero) begin
                if (state == ST_STOP) begin
                    state <= ST_IDLE;
                    valid_o <= 1'b1;
                end else begin
                    state <= state + 4'd1;
                    baud_cnt <= CW'(`CLKS_PER_BAUD - 1);
                end
            end else begin
                baud_cnt <= baud_cnt - 1'b1;
            end
        end
    end

    // data bits arrive lsb first
    always_ff @(posedge clk) begin
        if (baud_zero && state != ST_IDLE && state != ST_STOP) begin
            data_o <= {rx_sync, data_o[7:1]};
        end
    end

endmodule

// File: design/uart_tx.sv
`timescale 1ns/1ps
`include "la_macros.svh"

module uart_tx (
    input logic clk,
    input logic reset_i,
    input logic [7:0] data_i,
    input logic start_i,
    output logic done_o,
    output logic tx_o
);

    localparam int CW = $clog2(`CLKS_PER_BAUD);

    logic busy;
    logic [CW-1:0] baud_cnt;
    logic [8:0] buffer;
    logic [3:0] bit_index;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            busy <= 1'b0;
            baud_cnt <= '0;
            bit_index <= '0;
            done_o <= 1'b0;
            tx_o <= 1'b1;
        end else if (!busy) begin
            done_o <= 1'b0;
            tx_o <= 1'b1;
            if (start_i) begin
                busy <= 1'b1;
                buffer <= {1'b1, data_i};
                bit_index <= '0;
                baud_cnt <= CW'(`CLKS_PER_BAUD - 1);
                tx_o <= 1'b0;
            end
        end else begin
            baud_cnt <= baud_cnt - 1'b1;
            // done lands one cycle early so the next byte is ready at the frame end
            done_o <= (baud_cnt == CW'(2)) && (bit_index == 4'd9);
            if (baud_cnt == '0) begin
                baud_cnt <= CW'(`CLKS_PER_BAUD - 1);
                if (bit_index < 4'd9) begin
                    // eight data bits then the stop bit from buffer[8]
                    tx_o <= buffer[bit_index];
                    bit_index <= bit_index + 4'd1;
                end else if (start_i) begin
                    // back-to-back frame, no idle gap
                    buffer <= {1'b1, data_i};
                    bit_index <= '0;
                    tx_o <= 1'b0;
                end else begin
                    busy <= 1'b0;
                end
            end
        end
    end

endmodule

// File: design/bridge_rx.sv
`timescale 1ns/1ps
`include "la_macros.svh"

module bridge_rx (
    input logic clk,
    input logic reset_i,
    input logic [7:0] data_i,
    input logic valid_i,
    output la_pkg::bus_req_t req_o
);

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_READ,
        RX_WRITE
    } rx_state_e;

    rx_state_e state;
    logic [3:0] byte_num;
    // address and data nibbles, shifted in as they arrive
    logic [2*`BUS_WIDTH-1:0] digits;
    logic is_term;

    // uppercase only, lowercase is rejected
    function automatic logic is_hex(input logic [7:0] c);
        return (c >= "0" && c <= "9") || (c >= "A" && c <= "F");
    endfunction

    function automatic logic [3:0] hex_val(input logic [7:0] c);
        if (c <= "9") begin
            return 4'(c - "0");
        end
        return 4'(c - "A" + 8'd10);
    endfunction

    assign is_term = (data_i == 8'h0D) || (data_i == 8'h0A);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state <= RX_IDLE;
            byte_num <= '0;
            req_o.valid <= 1'b0;
        end else begin
            req_o.valid <= 1'b0;
            if (valid_i) begin
                if (state == RX_IDLE) begin
                    byte_num <= '0;
                    if (data_i == "R") state <= RX_READ;
                    if (data_i == "W") state <= RX_WRITE;
                end else if ((state == RX_READ && byte_num == 4'd4) ||
                             (state == RX_WRITE && byte_num == 4'd8)) begin
                    state <= RX_IDLE;
                    if (is_term) begin
                        req_o.valid <= 1'b1;
                        req_o.rw <= (state == RX_WRITE);
                        if (state == RX_WRITE) begin
                            req_o.addr.raw <= digits[2*`BUS_WIDTH-1:`BUS_WIDTH];
                            req_o.data <= digits[`BUS_WIDTH-1:0];
                        end else begin
                            req_o.addr.raw <= digits[`BUS_WIDTH-1:0];
                            req_o.data <= '0;
                        end
                    end
                end else if (is_hex(data_i)) begin
                    digits <= {digits[2*`BUS_WIDTH-5:0], hex_val(data_i)};
                    byte_num <= byte_num + 4'd1;
                end else begin
                    state <= RX_IDLE;
                end
            end
        end
    end

endmodule

// File: design/bridge_tx.sv
`timescale 1ns/1ps

module bridge_tx (
    input logic clk,
    input logic reset_i,
    input la_pkg::bus_rsp_t rsp_i,
    output logic [7:0] data_o,
    output logic start_o,
    input logic done_i
);

    logic busy;
    logic [15:0] buffer;
    logic [2:0] count;

    function automatic logic [7:0] to_hex(input logic [3:0] n);
        return (n < 4'd10) ? (8'h30 + 8'(n)) : (8'h37 + 8'(n));
    endfunction

    assign start_o = busy;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            busy <= 1'b0;
            count <= '0;
        end else if (!busy) begin
            // responses that come in while a reply is in flight are lost
            if (rsp_i.valid) begin
                busy <= 1'b1;
                buffer <= rsp_i.data;
                count <= '0;
            end
        end else if (done_i) begin
            if (count == 3'd6) begin
                busy <= 1'b0;
                count <= '0;
            end else begin
                count <= count + 3'd1;
            end
        end
    end

    // reply line: D, four digits, CR, LF
    always_comb begin
        case (count)
            3'd0: data_o = "D";
            3'd1: data_o = to_hex(buffer[15:12]);
            3'd2: data_o = to_hex(buffer[11:8]);
            3'd3: data_o = to_hex(buffer[7:4]);
            3'd4: data_o = to_hex(buffer[3:0]);
            3'd5: data_o = 8'h0D;
            default: data_o = 8'h0A;
        endcase
    end

endmodule

// File: design/la_trigger.sv
`timescale 1ns/1ps
`include "la_macros.svh"

module la_trigger (
    input logic clk,
    input logic reset_i,
    input la_pkg::bus_req_t req_i,
    output la_pkg::bus_req_t req_o,
    input la_pkg::probe_t probes_i,
    output la_pkg::probe_t probes_o,
    output logic trig_o
);

    localparam int IW = $clog2(`NUM_PROBES);

    la_pkg::trig_op_e op_q [`NUM_PROBES];
    logic [`NUM_PROBES-1:0] arg_q;
    logic [`NUM_PROBES-1:0] cur;
    logic [`NUM_PROBES-1:0] prev;
    logic [`NUM_PROBES-1:0] hit;
    logic [IW-1:0] sel;
    logic reg_hit;

    // offset 2k is the op of probe k, 2k+1 its argument
    assign sel = req_i.addr.split.offset[IW:1];
    assign reg_hit = req_i.valid && (req_i.addr.split.region == `REGION_TRIG) &&
                     (req_i.addr.split.offset < 2 * `NUM_PROBES);
    assign cur = probes_o;

    always_ff @(posedge clk) begin
        probes_o <= probes_i;
        prev <= cur;
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int k = 0; k < `NUM_PROBES; k++) begin
                op_q[k] <= la_pkg::DISABLE;
            end
            arg_q <= '0;
            req_o.valid <= 1'b0;
        end else begin
            req_o <= req_i;
            if (reg_hit && req_i.rw) begin
                if (req_i.addr.split.offset[0]) arg_q[sel] <= req_i.data[0];
                else op_q[sel] <= la_pkg::trig_op_e'(req_i.data[3:0]);
            end else if (reg_hit) begin
                if (req_i.addr.split.offset[0]) begin
                    req_o.data <= {{(`BUS_WIDTH-1){1'b0}}, arg_q[sel]};
                end else begin
                    req_o.data <= {{(`BUS_WIDTH-4){1'b0}}, op_q[sel]};
                end
            end
        end
    end

    always_comb begin
        for (int k = 0; k < `NUM_PROBES; k++) begin
            case (op_q[k])
                la_pkg::RISING: hit[k] = cur[k] & ~prev[k];
                la_pkg::FALLING: hit[k] = ~cur[k] & prev[k];
                la_pkg::CHANGING: hit[k] = cur[k] ^ prev[k];
                la_pkg::EQ: hit[k] = (cur[k] == arg_q[k]);
                la_pkg::NEQ: hit[k] = (cur[k] != arg_q[k]);
                default: hit[k] = 1'b0;
            endcase
        end
    end

    assign trig_o = |hit;

endmodule

// File: design/la_capture.sv
`timescale 1ns/1ps
`include "la_macros.svh"

module la_capture (
    input logic clk,
    input logic reset_i,
    input la_pkg::bus_req_t req_i,
    output la_pkg::bus_rsp_t rsp_o,
    input la_pkg::probe_t probes_i,
    input logic trig_i
);

    localparam int AW = `SAMPLE_ADDR_WIDTH;
    localparam logic [AW-1:0] LAST_IDX = AW'(`SAMPLE_DEPTH - 1);

    la_pkg::la_state_e state_q;
    logic [AW-1:0] wr_ptr;
    la_pkg::probe_t mem [`SAMPLE_DEPTH];
    la_pkg::probe_t mem_rdata_q;
    logic mem_we;
    logic [AW-1:0] mem_waddr;
    logic ctrl_wr;
    logic ctrl_rd;
    logic mem_rd;
    logic rd_valid_q;
    logic rd_mem_q;
    logic [`BUS_WIDTH-1:0] rd_data_q;

    assign ctrl_wr = req_i.valid && req_i.rw && (req_i.addr.split.region == `REGION_CTRL) &&
                     (req_i.addr.split.offset == 12'd1);
    assign ctrl_rd = (req_i.addr.split.region == `REGION_CTRL);
    assign mem_rd = (req_i.addr.split.region == `REGION_MEM) &&
                    (req_i.addr.split.offset < `SAMPLE_DEPTH);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q <= la_pkg::IDLE;
            wr_ptr <= '0;
        end else begin
            case (state_q)
                la_pkg::ARMED: begin
                    // sample 0 is written in the trigger cycle itself
                    if (trig_i) begin
                        state_q <= la_pkg::CAPTURING;
                        wr_ptr <= AW'(1);
                    end
                end
                la_pkg::CAPTURING: begin
                    wr_ptr <= wr_ptr + 1'b1;
                    if (wr_ptr == LAST_IDX) state_q <= la_pkg::CAPTURED;
                end
                default: wr_ptr <= '0;
            endcase
            // arm only from idle, a zero stops from anywhere
            if (ctrl_wr && req_i.data == 16'd1 && state_q == la_pkg::IDLE) begin
                state_q <= la_pkg::ARMED;
            end
            if (ctrl_wr && req_i.data == 16'd0) state_q <= la_pkg::IDLE;
        end
    end

    assign mem_we = (state_q == la_pkg::ARMED && trig_i) || (state_q == la_pkg::CAPTURING);
    assign mem_waddr = (state_q == la_pkg::CAPTURING) ? wr_ptr : '0;

    always_ff @(posedge clk) begin
        if (mem_we) mem[mem_waddr] <= probes_i;
        mem_rdata_q <= mem[req_i.addr.split.offset[AW-1:0]];
    end

    // two stage read path, the memory read sets the latency
    always_ff @(posedge clk) begin
        if (reset_i) begin
            rd_valid_q <= 1'b0;
            rsp_o.valid <= 1'b0;
        end else begin
            rd_valid_q <= req_i.valid && !req_i.rw;
            rsp_o.valid <= rd_valid_q;
        end
        rd_mem_q <= mem_rd;
        if (ctrl_rd) begin
            rd_data_q <= (req_i.addr.split.offset == '0) ?
                         {{(`BUS_WIDTH-2){1'b0}}, state_q} : '0;
        end else begin
            rd_data_q <= req_i.data;
        end
        rsp_o.data <= rd_mem_q ? {{(`BUS_WIDTH-`NUM_PROBES){1'b0}}, mem_rdata_q} : rd_data_q;
    end

endmodule

// File: design/debug_core.sv
`timescale 1ns/1ps

module debug_core (
    input logic clk,
    input logic reset_i,
    input logic rx_i,
    output logic tx_o,
    input la_pkg::probe_t probes_i
);

    logic [7:0] rx_byte;
    logic rx_valid;
    la_pkg::bus_req_t req_brx;
    la_pkg::bus_req_t req_trig;
    la_pkg::bus_rsp_t rsp_cap;
    la_pkg::probe_t probes_q;
    logic trig;
    logic [7:0] tx_byte;
    logic tx_start;
    logic tx_done;

    uart_rx i_uart_rx (.clk(clk), .reset_i(reset_i), .rx_i(rx_i),
                       .data_o(rx_byte), .valid_o(rx_valid));

    bridge_rx i_bridge_rx (.clk(clk), .reset_i(reset_i), .data_i(rx_byte),
                           .valid_i(rx_valid), .req_o(req_brx));

    // trigger registers first, then control and sample memory
    la_trigger i_la_trigger (.clk(clk), .reset_i(reset_i), .req_i(req_brx),
                             .req_o(req_trig), .probes_i(probes_i),
                             .probes_o(probes_q), .trig_o(trig));

    la_capture i_la_capture (.clk(clk), .reset_i(reset_i), .req_i(req_trig),
                             .rsp_o(rsp_cap), .probes_i(probes_q), .trig_i(trig));

    bridge_tx i_bridge_tx (.clk(clk), .reset_i(reset_i), .rsp_i(rsp_cap),
                           .data_o(tx_byte), .start_o(tx_start), .done_i(tx_done));

    uart_tx i_uart_tx (.clk(clk), .reset_i(reset_i), .data_i(tx_byte),
                       .start_i(tx_start), .done_o(tx_done), .tx_o(tx_o));

endmodule

// File: test/debug_core_sva.sv
`timescale 1ns/1ps

module debug_core_sva (
    input logic clk,
    input logic reset_i,
    input la_pkg::bus_req_t req_brx_i,
    input la_pkg::bus_req_t req_trig_i,
    input la_pkg::bus_rsp_t rsp_cap_i,
    input logic tx_start_i,
    input logic tx_line_i
);

    int error_count = 0;

    // bridge requests are single-cycle pulses with a gap
    no_back_to_back: assert property (@(posedge clk) disable iff (reset_i)
        req_brx_i.valid |=> !req_brx_i.valid)
    else begin
        $error("bus request pulses on two consecutive cycles");
        error_count++;
    end

    // serial line rests high while no reply is being sent
    line_idle_high: assert property (@(posedge clk) disable iff (reset_i)
        !tx_start_i |-> tx_line_i)
    else begin
        $error("tx line low while the reply transmitter is idle");
        error_count++;
    end

    rsp_after_read: assert property (@(posedge clk) disable iff (reset_i)
        (req_trig_i.valid && !req_trig_i.rw) |-> ##2 rsp_cap_i.valid)
    else begin
        $error("read request not answered two cycles later");
        error_count++;
    end

    rsp_has_read: assert property (@(posedge clk) disable iff (reset_i)
        rsp_cap_i.valid |-> $past(req_trig_i.valid && !req_trig_i.rw, 2))
    else begin
        $error("response without a read request two cycles earlier");
        error_count++;
    end

endmodule

bind debug_core debug_core_sva i_debug_core_sva (
    .clk(clk),
    .reset_i(reset_i),
    .req_brx_i(req_brx),
    .req_trig_i(req_trig),
    .rsp_cap_i(rsp_cap),
    .tx_start_i(tx_start),
    .tx_line_i(tx_o)
);

// File: test/debug_core_tb.sv
`timescale 1ns/1ps
`include "la_macros.svh"

module debug_core_tb;

    localparam int CHAR_CLKS = 10 * `CLKS_PER_BAUD;
    // about 80 serial transactions of at most 13 characters each, with margin
    localparam int TIMEOUT_CYCLES = 80 * 16 * CHAR_CLKS;

    logic clk;
    logic reset_i;
    logic rx_i;
    logic tx_o;
    la_pkg::probe_t probes;
    integer seed = 28;
    int errors = 0;
    int checks = 0;
    int cycles = 0;
    logic [6:0] exp_samples [`SAMPLE_DEPTH];

    debug_core i_debug_core (
        .clk(clk),
        .reset_i(reset_i),
        .rx_i(rx_i),
        .tx_o(tx_o),
        .probes_i(probes)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    function automatic logic [7:0] hex_char(input logic [3:0] n);
        if (n < 4'd10) return 8'h30 + 8'(n);
        return 8'h41 + 8'(n) - 8'd10;
    endfunction

    function automatic string hex4(input logic [15:0] v);
        return $sformatf("%c%c%c%c", hex_char(v[15:12]), hex_char(v[11:8]),
                         hex_char(v[7:4]), hex_char(v[3:0]));
    endfunction

    // {is uppercase hex, value}
    function automatic logic [4:0] char_nibble(input logic [7:0] c);
        if (c >= 8'h30 && c <= 8'h39) return {1'b1, 4'(c - 8'h30)};
        if (c >= 8'h41 && c <= 8'h46) return {1'b1, 4'(c - 8'h37)};
        return 5'd0;
    endfunction

    task automatic check_equal(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t ns: %s = %0h, expected %0h", $time, name, got, exp);
        end
    endtask

    task automatic print_counts();
        $display("checks: %0d, testbench errors: %0d, assertion errors: %0d",
                 checks, errors, i_debug_core.i_debug_core_sva.error_count);
    endtask

    // 8N1 frame on rx_i
    task automatic send_byte(input logic [7:0] b);
        @(negedge clk);
        rx_i = 1'b0;
        for (int i = 0; i < 8; i++) begin
            repeat (`CLKS_PER_BAUD) @(negedge clk);
            rx_i = b[i];
        end
        repeat (`CLKS_PER_BAUD) @(negedge clk);
        rx_i = 1'b1;
        repeat (`CLKS_PER_BAUD) @(negedge clk);
    endtask

    task automatic send_line(input string body, input logic [7:0] term);
        for (int i = 0; i < body.len(); i++) begin
            send_byte(body[i]);
        end
        send_byte(term);
    endtask

    // waits up to limit cycles for a start bit, then samples each bit mid-bit
    task automatic recv_byte(input int limit, output logic [7:0] b, output bit got);
        int n;
        n = 0;
        got = 1'b0;
        b = '0;
        while (tx_o !== 1'b0 && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (tx_o === 1'b0) begin
            got = 1'b1;
            repeat (`CLKS_PER_BAUD / 2) @(negedge clk);
            for (int i = 0; i < 8; i++) begin
                repeat (`CLKS_PER_BAUD) @(negedge clk);
                b[i] = tx_o;
            end
            repeat (`CLKS_PER_BAUD) @(negedge clk);
            if (tx_o !== 1'b1) begin
                errors++;
                $display("reply byte has a low stop bit at %0t ns", $time);
            end
        end
    endtask

    task automatic recv_reply(input int first_wait, output logic [6:0][7:0] line,
                              output bit ok);
        bit got;
        ok = 1'b1;
        line = '0;
        for (int i = 0; i < 7 && ok; i++) begin
            recv_byte((i == 0) ? first_wait : 2 * CHAR_CLKS, line[i], got);
            ok = got;
        end
    endtask

    task automatic watch_quiet(input int n, output bit quiet);
        quiet = 1'b1;
        repeat (n) begin
            @(negedge clk);
            if (tx_o !== 1'b1) quiet = 1'b0;
        end
    endtask

    // command that must leave tx_o idle for two character times after it
    task automatic send_no_reply(input string body, input logic [7:0] term);
        bit quiet;
        fork
            send_line(body, term);
            watch_quiet((body.len() + 3) * CHAR_CLKS, quiet);
        join
        if (!quiet) begin
            errors++;
            $display("unexpected reply to command %s at %0t ns", body, $time);
        end
    endtask

    task automatic write_reg(input logic [15:0] addr, input logic [15:0] data);
        send_no_reply($sformatf("W%s%s", hex4(addr), hex4(data)), 8'h0A);
    endtask

    task automatic read_expect(input logic [15:0] addr, input logic [15:0] exp,
                               input string name);
        string body;
        logic [6:0][7:0] line;
        logic [15:0] val;
        logic [4:0] nib;
        bit ok;
        body = $sformatf("R%s", hex4(addr));
        fork
            send_line(body, 8'h0D);
            recv_reply((body.len() + 3) * CHAR_CLKS, line, ok);
        join
        if (!ok) begin
            errors++;
            $display("missing or incomplete reply to command %s at %0t ns", body, $time);
        end else begin
            check_equal({name, " lead char"}, line[0], 8'h44);
            val = '0;
            for (int i = 1; i <= 4; i++) begin
                nib = char_nibble(line[i]);
                if (!nib[4]) begin
                    errors++;
                    $display("reply to %s holds a non-hex digit at %0t ns", body, $time);
                end
                val = {val[11:0], nib[3:0]};
            end
            check_equal(name, val, exp);
            check_equal({name, " cr"}, line[5], 8'h0D);
            check_equal({name, " lf"}, line[6], 8'h0A);
        end
    endtask

    task automatic reset_state_reads();
        check_equal("tx_o after reset", tx_o, 1'b1);
        read_expect(16'h0000, 16'h0000, "state after reset");
        read_expect(16'h3000, 16'h0000, "unmapped read");
    endtask

    task automatic trigger_reg_roundtrip();
        write_reg(16'h1000, 16'h0001);
        read_expect(16'h1000, 16'h0001, "probe 0 op");
        // argument register keeps one bit only
        write_reg(16'h1001, 16'hFFFF);
        read_expect(16'h1001, 16'h0001, "probe 0 arg");
    endtask

    task automatic malformed_commands();
        send_no_reply("R00G0", 8'h0D);
        send_no_reply("r0000", 8'h0D);
        send_no_reply("W1000001", 8'h0A);
        read_expect(16'h0000, 16'h0000, "state after malformed");
    endtask

    task automatic capture_after_trigger();
        int rnd;
        la_pkg::probe_t vec;
        write_reg(16'h1000, 16'h0001);
        write_reg(16'h0001, 16'h0001);
        read_expect(16'h0000, 16'h0001, "state armed");
        // noise on the other probes, valid_in held low
        repeat (8) begin
            @(negedge clk);
            rnd = $random(seed);
            vec = rnd[6:0];
            vec.valid_in = 1'b0;
            probes = vec;
        end
        // rising valid_in in the first vector, each vector becomes one sample
        for (int k = 0; k < `SAMPLE_DEPTH; k++) begin
            @(negedge clk);
            rnd = $random(seed);
            vec = rnd[6:0];
            if (k == 0) vec.valid_in = 1'b1;
            probes = vec;
            exp_samples[k] = vec;
        end
        @(negedge clk);
        probes = '0;
        repeat (4) @(negedge clk);
        read_expect(16'h0000, 16'h0003, "state captured");
        for (int k = 0; k < `SAMPLE_DEPTH; k++) begin
            read_expect({4'h2, 12'(k)}, 16'(exp_samples[k]), $sformatf("sample[%0d]", k));
        end
    endtask

    task automatic disarm_to_idle();
        write_reg(16'h0001, 16'h0000);
        read_expect(16'h0000, 16'h0000, "state after disarm");
    endtask

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            print_counts();
            $display("Simulation failed");
            $finish;
        end
    end

    initial begin
        reset_i = 1'b1;
        rx_i = 1'b1;
        probes = '0;
        repeat (5) @(negedge clk);
        reset_i = 1'b0;
        repeat (10) @(negedge clk);
        reset_state_reads();
        trigger_reg_roundtrip();
        malformed_commands();
        capture_after_trigger();
        disarm_to_idle();
        repeat (10) @(negedge clk);
        print_counts();
        if (errors == 0 && i_debug_core.i_debug_core_sva.error_count == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: debug_core.f
+incdir+design
design/la_pkg.sv
design/uart_rx.sv
design/uart_tx.sv
design/bridge_rx.sv
design/bridge_tx.sv
design/la_trigger.sv
design/la_capture.sv
design/debug_core.sv
test/debug_core_sva.sv
test/debug_core_tb.sv
